//--- Bender.yml
package:
  name: icache_core

sources:
  # Shared packages
  - common/icache_cfg_pkg.sv
  - common/icache_biu_pkg.sv
  # Design
  - source/icache_setup.sv
  - icache_mem/icache_memory.sv
  - source/icache_hit_ctrl.sv
  - source/icache_biu_ctrl.sv
  - source/icache_core.sv
  # Testbench
  - target: test
    files:
      - dv/biu_mem_model.sv
      - dv/tb_icache_core.sv

//--- common/icache_biu_pkg.sv
// Bus transfer size and burst enums, fill command and bus request structs
`default_nettype none

package icache_biu_pkg;

  // Line address width, offset bits dropped
  localparam int LINE_ADR_BITS = icache_cfg_pkg::PLEN - icache_cfg_pkg::OFFS_BITS - 2;

  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010,
    DWORD = 3'b011
  } biu_size_t;

  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR4  = 3'b011                                      // Four beats, incrementing
  } biu_type_t;

  // Hit stage to bus controller, held until fill done
  typedef struct packed {
    logic                     req;
    logic [LINE_ADR_BITS-1:0] line_adr;
  } fill_cmd_t;

  typedef struct packed {
    logic [icache_cfg_pkg::PLEN-1:0] adr;
    biu_size_t                       size;
    biu_type_t                       btype;
  } biu_req_t;

endpackage

`default_nettype wire

//--- common/icache_cfg_pkg.sv
// Cache geometry constants, fetch address union and pipeline structs
`default_nettype none

package icache_cfg_pkg;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------
  localparam int XLEN       = 32;                        // Data word width
  localparam int PLEN       = 32;                        // Address width
  localparam int BLOCK_SIZE = 16;                        // Bytes per line
  localparam int WAYS       = 2;
  localparam int SETS       = 16;
  localparam int BURST_SIZE = BLOCK_SIZE * 8 / XLEN;     // Beats per fill
  localparam int IDX_BITS   = $clog2(SETS);
  localparam int OFFS_BITS  = $clog2(BURST_SIZE);        // Word offset in line
  localparam int TAG_BITS   = PLEN - IDX_BITS - OFFS_BITS - 2;
  localparam int BLK_BITS   = 8 * BLOCK_SIZE;
  localparam int LFSR_BITS  = 7;                         // Victim generator width

  // --------------------------------------------------
  // Types
  // --------------------------------------------------
  typedef struct packed {
    logic [TAG_BITS-1:0]  tag;
    logic [IDX_BITS-1:0]  idx;
    logic [OFFS_BITS-1:0] offs;
    logic [1:0]           byte_offs;                     // Always 0 for word fetch
  } fetch_fields_t;

  // Fetch address, seen as a word or as its cache fields
  typedef union packed {
    logic [PLEN-1:0] adr;
    fetch_fields_t   f;
  } fetch_adr_t;

  typedef struct packed {
    logic       valid;
    fetch_adr_t adr;
  } fetch_req_t;

  typedef logic [BLK_BITS-1:0] line_t;

  typedef struct packed {
    logic  hit;
    line_t line;                                         // Line of the hitting way
  } cache_lookup_t;

endpackage

`default_nettype wire

//--- dv/biu_mem_model.sv
// Bus responder model with random strobe and beat delays and address-derived data
`timescale 1ns/1ps
`default_nettype none

module biu_mem_model (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic                            stb_i,
  input  wire icache_biu_pkg::biu_req_t        req_i,
  output logic                                 stb_ack_o,
  output logic                                 ack_o,
  output logic [icache_cfg_pkg::XLEN-1:0]      q_o
);

  import icache_cfg_pkg::*;

  localparam logic [31:0] SEED = 32'd42352;

  logic [31:0]     rnd_q;                        // Generator state
  logic [PLEN-1:0] base;                         // Burst start address

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Zero to three idle cycles
  task automatic wait_random();
    rnd_q = xorshift32(rnd_q);
    repeat (rnd_q[1:0]) @(negedge clk_i);
  endtask

  // --------------------------------------------------
  // Responder, all outputs change on the falling edge
  // --------------------------------------------------
  initial begin
    stb_ack_o = 1'b0;
    ack_o     = 1'b0;
    q_o       = '0;
    rnd_q     = SEED;
    forever begin
      @(negedge clk_i);
      if (rst_ni && stb_i) begin
        base = req_i.adr;
        wait_random();
        stb_ack_o = 1'b1;                        // Strobe accepted
        @(negedge clk_i);
        stb_ack_o = 1'b0;
        for (int beat = 0; beat < BURST_SIZE; beat++) begin
          wait_random();                         // Gap before each beat
          ack_o = 1'b1;
          q_o   = ~(base + PLEN'(4 * beat));     // Word data is its inverted address
          @(negedge clk_i);
          ack_o = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_icache_core.sv
// Testbench top for the instruction cache core, stimulus, scoreboard, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_icache_core;

  import icache_cfg_pkg::*;
  import icache_biu_pkg::*;

  localparam int CLK_PERIOD = 40;
  // Room for about 17 fills of up to 30 cycles plus hits and flushes with wide margin
  localparam int MAX_CYCLES = 4000;

  localparam logic [31:0] LINE_A    = 32'h0000_2040;   // Set 4
  localparam logic [31:0] LINE_B    = 32'h0000_3080;   // Set 8
  localparam logic [31:0] LINE_C    = 32'h0000_4000;   // Set 0
  localparam logic [31:0] CONF_BASE = 32'h0000_00C0;   // Set 12 with tag stepping by 0x10000

  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] cycle;                                // Cycle count at acceptance
    logic        hit;                                  // Two-cycle latency expected
  } pend_t;

  logic       clk_i, rst_ni;
  logic       mem_req_i, mem_flush_i, cache_flush_i;
  fetch_adr_t mem_adr_i;
  logic       mem_stall_o, parcel_valid_o, biu_stb_o;
  logic       biu_stb_ack_i, biu_ack_i;
  logic [XLEN-1:0] parcel_o, biu_q_i;
  biu_req_t   biu_req_o;

  pend_t       pending[$];                             // Accepted and not yet returned
  pend_t       done_req;
  logic [31:0] cycle_cnt    = '0;
  logic        stb_q        = 1'b0;
  int          mismatch_cnt = 0;
  int          fail_cnt     = 0;
  int          fill_cnt     = 0;
  int          fills_before;
  string       test_name;

  icache_core UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mem_req_i      (mem_req_i),
    .mem_flush_i    (mem_flush_i),
    .cache_flush_i  (cache_flush_i),
    .mem_adr_i      (mem_adr_i),
    .mem_stall_o    (mem_stall_o),
    .parcel_o       (parcel_o),
    .parcel_valid_o (parcel_valid_o),
    .biu_stb_o      (biu_stb_o),
    .biu_req_o      (biu_req_o),
    .biu_stb_ack_i  (biu_stb_ack_i),
    .biu_ack_i      (biu_ack_i),
    .biu_q_i        (biu_q_i)
  );

  biu_mem_model u_bus (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .stb_i     (biu_stb_o),
    .req_i     (biu_req_o),
    .stb_ack_o (biu_stb_ack_i),
    .ack_o     (biu_ack_i),
    .q_o       (biu_q_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt == MAX_CYCLES);
    $display("Timeout after %0d cycles in test %s", MAX_CYCLES, test_name);
    $display("Simulation failed");
    $finish;
  end

  // --------------------------------------------------
  // Monitor of registered outputs on the falling edge
  // --------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni && parcel_valid_o) begin
      assert (pending.size() != 0) else begin
        $display("Parcel returned with no request pending in %s", test_name);
        fail_cnt++;
      end
      if (pending.size() != 0) begin
        done_req = pending.pop_front();
        assert (parcel_o == ~done_req.adr) else begin
          $display("Mismatch in %s: expected %h, actual %h", test_name, ~done_req.adr,
                   parcel_o);
          mismatch_cnt++;
        end
        if (done_req.hit) begin
          assert (cycle_cnt - done_req.cycle == 2) else begin
            $display("Mismatch in %s: hit latency expected 2, actual %0d", test_name,
                     cycle_cnt - done_req.cycle);
            mismatch_cnt++;
          end
        end
      end
    end
    // A new strobe starts one line fill for the oldest pending request
    if (rst_ni && biu_stb_o && !stb_q) begin
      fill_cnt++;
      assert (biu_req_o.btype == INCR4 && biu_req_o.size == WORD) else begin
        $display("Fill request in %s is not an INCR4 word burst", test_name);
        fail_cnt++;
      end
      if (pending.size() != 0) begin
        assert (biu_req_o.adr == {pending[0].adr[31:4], 4'h0}) else begin
          $display("Mismatch in %s: fill address expected %h, actual %h", test_name,
                   {pending[0].adr[31:4], 4'h0}, biu_req_o.adr);
          mismatch_cnt++;
        end
      end
    end
    stb_q = biu_stb_o;
  end

  // --------------------------------------------------
  // Stimulus tasks driving inputs on the falling edge
  // --------------------------------------------------
  task automatic fetch(input logic [31:0] adr, input logic expect_hit);
    pend_t req;
    @(negedge clk_i);
    mem_req_i     = 1'b1;
    mem_adr_i.adr = adr;
    #(CLK_PERIOD / 4);                                 // Stall is stable mid low phase
    while (mem_stall_o) begin
      assert (!expect_hit) else begin
        $display("Stall raised during hit fetch of %h in %s", adr, test_name);
        fail_cnt++;
      end
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
    end
    req.adr   = adr;                                   // Taken at the next rising edge
    req.cycle = cycle_cnt;
    req.hit   = expect_hit;
    pending.push_back(req);
  endtask

  // Idle until every accepted request has returned
  task automatic drain();
    @(negedge clk_i);
    mem_req_i = 1'b0;
    #(CLK_PERIOD / 4);
    while (pending.size() != 0 || mem_stall_o) begin
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
    end
  endtask

  task automatic wait_for_stall();
    @(negedge clk_i);
    mem_req_i = 1'b0;
    #(CLK_PERIOD / 4);
    while (!mem_stall_o) begin
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
    end
  endtask

  task automatic pulse_mem_flush();
    @(negedge clk_i);
    mem_req_i   = 1'b0;
    mem_flush_i = 1'b1;
    #(CLK_PERIOD / 4);
    assert (pending.size() != 0) else begin
      $display("Pipeline flush in %s found no request in flight", test_name);
      fail_cnt++;
    end
    pending.delete();                                  // Killed requests never return
    @(negedge clk_i);
    mem_flush_i = 1'b0;
  endtask

  task automatic pulse_cache_flush();
    @(negedge clk_i);
    mem_req_i     = 1'b0;
    cache_flush_i = 1'b1;
    #(CLK_PERIOD / 4);
    assert (mem_stall_o) else begin
      $display("Cache flush did not stall the core");
      fail_cnt++;
    end
    @(negedge clk_i);
    cache_flush_i = 1'b0;
  endtask

  task automatic check_fills(input int expected);
    assert (fill_cnt == expected) else begin
      $display("Mismatch in %s: fills expected %0d, actual %0d", test_name, expected,
               fill_cnt);
      mismatch_cnt++;
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    mem_req_i     = 1'b0;
    mem_flush_i   = 1'b0;
    cache_flush_i = 1'b0;
    mem_adr_i     = '0;
    rst_ni        = 1'b0;
    test_name     = "reset";
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    #(CLK_PERIOD / 4);
    assert (!mem_stall_o && !parcel_valid_o && !biu_stb_o) else begin
      $display("Outputs not idle after reset");
      fail_cnt++;
    end

    test_name    = "miss_fill";
    fills_before = fill_cnt;
    fetch(LINE_A + 8, 1'b0);
    drain();
    check_fills(fills_before + 1);

    test_name = "hit_latency";                         // Every word of the filled line
    for (int w = 0; w < BURST_SIZE; w++) begin
      fetch(LINE_A + 4 * w, 1'b1);
      drain();
    end
    check_fills(fills_before + 1);

    test_name = "back_to_back";
    fetch(LINE_B, 1'b0);
    drain();
    fills_before = fill_cnt;
    for (int i = 0; i < 2 * BURST_SIZE; i++) begin
      fetch(((i < BURST_SIZE) ? LINE_A : LINE_B) + 4 * (i % BURST_SIZE), 1'b1);
    end
    drain();
    check_fills(fills_before);

    test_name    = "conflict";                         // Three tags sharing two ways
    fills_before = fill_cnt;
    for (int i = 0; i < 12; i++) begin
      fetch(CONF_BASE + ((i % 3) << 16) + 4 * (i % 4), 1'b0);
    end
    drain();
    // Three cold misses, then each run of the three tags misses at least once
    assert (fill_cnt - fills_before >= 6) else begin
      $display("Conflict test caused fewer than six fills");
      fail_cnt++;
    end

    test_name = "pipe_flush";
    fetch(LINE_A, 1'b1);
    fetch(LINE_A + 4, 1'b1);
    pulse_mem_flush();                                 // Second hit in flight
    drain();
    fetch(LINE_C, 1'b0);
    wait_for_stall();
    pulse_mem_flush();                                 // Fill running
    drain();
    fetch(LINE_C + 12, 1'b0);
    drain();

    test_name    = "cache_flush";
    fills_before = fill_cnt;
    fetch(LINE_A, 1'b1);
    fetch(LINE_B, 1'b1);
    drain();
    check_fills(fills_before);
    pulse_cache_flush();
    drain();
    fetch(LINE_A, 1'b0);                               // Both lines miss again
    fetch(LINE_B, 1'b0);
    drain();
    check_fills(fills_before + 2);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- icache_mem/icache_memory.sv
// Tag, valid and data arrays, two-way hit compare, LFSR victim and flush clear
`timescale 1ns/1ps
`default_nettype none

module icache_memory (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire logic [icache_cfg_pkg::IDX_BITS-1:0] rd_idx_i,
  input  wire logic [icache_cfg_pkg::IDX_BITS-1:0] wr_idx_i,
  input  wire logic [icache_cfg_pkg::TAG_BITS-1:0] cmp_tag_i,  // Also the fill tag
  input  wire logic                                fill_we_i,
  input  wire icache_cfg_pkg::line_t               fill_line_i,
  input  wire logic                                flush_we_i,
  input  wire logic [icache_cfg_pkg::IDX_BITS-1:0] flush_idx_i,
  output icache_cfg_pkg::cache_lookup_t            lookup_o
);

  import icache_cfg_pkg::*;

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  logic [TAG_BITS-1:0]  tag_mem   [WAYS][SETS];
  line_t                data_mem  [WAYS][SETS];
  logic [WAYS-1:0]      valid_mem [SETS];

  logic [TAG_BITS-1:0]  tag_q     [WAYS];            // Registered read
  line_t                data_q    [WAYS];
  logic [WAYS-1:0]      valid_q;

  logic [LFSR_BITS-1:0] lfsr_q;
  logic [WAYS-1:0]      way_sel;                     // One-hot victim
  logic [WAYS-1:0]      way_hit;

  // Random replacement, frozen during a line write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;                                  // XNOR taps, all-zero is legal
    end else if (!fill_we_i) begin
      lfsr_q <= {lfsr_q[LFSR_BITS-2:0], lfsr_q[LFSR_BITS-1] ~^ lfsr_q[LFSR_BITS-2]};
    end
  end

  assign way_sel = WAYS'(1) << lfsr_q[$clog2(WAYS)-1:0];

  // Tag and data arrays
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < WAYS; w++) begin
      if (fill_we_i && way_sel[w]) begin
        tag_mem[w][wr_idx_i]  <= cmp_tag_i;
        data_mem[w][wr_idx_i] <= fill_line_i;
      end
      tag_q[w]  <= tag_mem[w][rd_idx_i];             // Read before write
      data_q[w] <= data_mem[w][rd_idx_i];
    end
  end

  // Valid bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < SETS; s++) begin
        valid_mem[s] <= '0;
      end
      valid_q <= '0;
    end else begin
      if (flush_we_i) begin
        valid_mem[flush_idx_i] <= '0;                // One set per cycle
      end else if (fill_we_i) begin
        valid_mem[wr_idx_i] <= valid_mem[wr_idx_i] | way_sel;
      end
      valid_q <= valid_mem[rd_idx_i];
    end
  end

  // --------------------------------------------------
  // Hit compare and way mux
  // --------------------------------------------------
  always_comb begin
    lookup_o.line = '0;
    for (int w = 0; w < WAYS; w++) begin
      way_hit[w] = valid_q[w] && (tag_q[w] == cmp_tag_i);
      if (way_hit[w]) begin
        lookup_o.line = data_q[w];
      end
    end
    lookup_o.hit = |way_hit;
  end

endmodule

`default_nettype wire

//--- source/icache_biu_ctrl.sv
// Bus FSM, INCR4 burst issue, beat counting and refill line assembly
`timescale 1ns/1ps
`default_nettype none

module icache_biu_ctrl (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire icache_biu_pkg::fill_cmd_t   fill_cmd_i,
  output logic                             fill_done_o,
  output icache_cfg_pkg::line_t            biu_line_o,
  output logic                             biu_stb_o,
  output icache_biu_pkg::biu_req_t         biu_req_o,
  input  wire logic                        biu_stb_ack_i,
  input  wire logic                        biu_ack_i,
  input  wire logic [icache_cfg_pkg::XLEN-1:0] biu_q_i
);

  import icache_cfg_pkg::*;
  import icache_biu_pkg::*;

  localparam int BEAT_BITS = $clog2(BURST_SIZE);

  typedef enum logic [1:0] {IDLE, STROBE, BURST} state_t;

  state_t               state_q;
  logic [BEAT_BITS-1:0] beat_cnt_q;
  logic                 last_beat;
  logic [PLEN-1:0]      adr_q;                       // Line base address
  line_t                line_q;

  assign last_beat = biu_ack_i && (beat_cnt_q == BEAT_BITS'(BURST_SIZE - 1));

  // --------------------------------------------------
  // Bus FSM
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      beat_cnt_q  <= '0;
      fill_done_o <= 1'b0;
    end else begin
      fill_done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          // Command still high in the done cycle
          if (fill_cmd_i.req && !fill_done_o) state_q <= STROBE;
        end
        STROBE: begin
          if (biu_stb_ack_i) begin
            state_q    <= BURST;
            beat_cnt_q <= '0;
          end
        end
        BURST: begin
          if (biu_ack_i) beat_cnt_q <= beat_cnt_q + 1'b1;
          if (last_beat) begin
            state_q     <= IDLE;
            fill_done_o <= 1'b1;                     // One cycle after beat four
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Address capture and beat shift register
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && fill_cmd_i.req) begin
      adr_q <= {fill_cmd_i.line_adr, {(PLEN - LINE_ADR_BITS){1'b0}}};
    end
    if (state_q == BURST && biu_ack_i) begin
      line_q <= {biu_q_i, line_q[BLK_BITS-1:XLEN]};  // Word 0 ends at bottom
    end
  end

  assign biu_stb_o       = (state_q == STROBE);
  assign biu_req_o.adr   = adr_q;
  assign biu_req_o.size  = WORD;
  assign biu_req_o.btype = INCR4;
  assign biu_line_o      = line_q;

endmodule

`default_nettype wire

//--- source/icache_core.sv
// Instruction cache top, setup stage, memory, hit controller and bus controller
`timescale 1ns/1ps
`default_nettype none

module icache_core (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic                            mem_req_i,
  input  wire logic                            mem_flush_i,
  input  wire logic                            cache_flush_i,
  input  wire icache_cfg_pkg::fetch_adr_t      mem_adr_i,
  output logic                                 mem_stall_o,
  output logic [icache_cfg_pkg::XLEN-1:0]      parcel_o,
  output logic                                 parcel_valid_o,
  output logic                                 biu_stb_o,
  output icache_biu_pkg::biu_req_t             biu_req_o,
  input  wire logic                            biu_stb_ack_i,
  input  wire logic                            biu_ack_i,
  input  wire logic [icache_cfg_pkg::XLEN-1:0] biu_q_i
);

  import icache_cfg_pkg::*;
  import icache_biu_pkg::*;

  fetch_req_t          setup_req;
  logic [IDX_BITS-1:0] rd_idx, wr_idx, flush_idx;
  logic [TAG_BITS-1:0] cmp_tag;
  cache_lookup_t       lookup;
  logic                fill_we, flush_we, fill_done;
  line_t               biu_line;
  fill_cmd_t           fill_cmd;

  // --------------------------------------------------
  // Read pipeline
  // --------------------------------------------------
  icache_setup u_setup (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stall_i     (mem_stall_o),
    .flush_i     (mem_flush_i),
    .req_i       (mem_req_i),
    .adr_i       (mem_adr_i),
    .setup_req_o (setup_req),
    .rd_idx_o    (rd_idx)
  );

  icache_memory u_memory (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_idx_i    (rd_idx),
    .wr_idx_i    (wr_idx),
    .cmp_tag_i   (cmp_tag),
    .fill_we_i   (fill_we),
    .fill_line_i (biu_line),                         // Same line as the parcel
    .flush_we_i  (flush_we),
    .flush_idx_i (flush_idx),
    .lookup_o    (lookup)
  );

  icache_hit_ctrl u_hit_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (mem_flush_i),
    .cache_flush_i  (cache_flush_i),
    .setup_req_i    (setup_req),
    .lookup_i       (lookup),
    .fill_done_i    (fill_done),
    .biu_line_i     (biu_line),
    .stall_o        (mem_stall_o),
    .fill_we_o      (fill_we),
    .flush_we_o     (flush_we),
    .wr_idx_o       (wr_idx),
    .flush_idx_o    (flush_idx),
    .cmp_tag_o      (cmp_tag),
    .fill_cmd_o     (fill_cmd),
    .parcel_o       (parcel_o),
    .parcel_valid_o (parcel_valid_o)
  );

  // --------------------------------------------------
  // Bus side
  // --------------------------------------------------
  icache_biu_ctrl u_biu_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fill_cmd_i    (fill_cmd),
    .fill_done_o   (fill_done),
    .biu_line_o    (biu_line),
    .biu_stb_o     (biu_stb_o),
    .biu_req_o     (biu_req_o),
    .biu_stb_ack_i (biu_stb_ack_i),
    .biu_ack_i     (biu_ack_i),
    .biu_q_i       (biu_q_i)
  );

endmodule

`default_nettype wire

//--- source/icache_hit_ctrl.sv
// Hit stage, front-end FSM for lookup, miss, fill and flush, parcel output
`timescale 1ns/1ps
`default_nettype none

module icache_hit_ctrl (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  input  wire logic                                 flush_i,
  input  wire logic                                 cache_flush_i,
  input  wire icache_cfg_pkg::fetch_req_t           setup_req_i,
  input  wire icache_cfg_pkg::cache_lookup_t        lookup_i,
  input  wire logic                                 fill_done_i,
  input  wire icache_cfg_pkg::line_t                biu_line_i,
  output logic                                      stall_o,
  output logic                                      fill_we_o,
  output logic                                      flush_we_o,
  output logic [icache_cfg_pkg::IDX_BITS-1:0]       wr_idx_o,
  output logic [icache_cfg_pkg::IDX_BITS-1:0]       flush_idx_o,
  output logic [icache_cfg_pkg::TAG_BITS-1:0]       cmp_tag_o,
  output icache_biu_pkg::fill_cmd_t                 fill_cmd_o,
  output logic [icache_cfg_pkg::XLEN-1:0]           parcel_o,
  output logic                                      parcel_valid_o
);

  import icache_cfg_pkg::*;

  typedef enum logic [1:0] {LOOKUP, MISS, FILL_WAIT, FLUSH} state_t;

  state_t              state_q, state_d;
  fetch_adr_t          miss_adr_q;                   // Request being filled
  logic                killed_q;                     // Fill request flushed away
  logic                flush_pend_q;                 // Cache flush seen while busy
  logic [IDX_BITS-1:0] flush_cnt_q;
  logic                flush_go;
  logic                lookup_hit, lookup_miss;
  logic [XLEN-1:0]     hit_word, fill_word;

  // --------------------------------------------------
  // Decisions
  // --------------------------------------------------
  assign flush_go    = cache_flush_i || flush_pend_q;
  assign lookup_hit  = (state_q == LOOKUP) && setup_req_i.valid && lookup_i.hit
                       && !flush_i && !flush_go;
  assign lookup_miss = (state_q == LOOKUP) && setup_req_i.valid && !lookup_i.hit
                       && !flush_i && !flush_go;

  assign hit_word  = lookup_i.line[setup_req_i.adr.f.offs * XLEN +: XLEN];
  assign fill_word = biu_line_i[miss_adr_q.f.offs * XLEN +: XLEN];

  always_comb begin
    state_d = state_q;
    case (state_q)
      LOOKUP: begin
        if (flush_go) begin
          state_d = FLUSH;
        end else if (lookup_miss) begin
          state_d = MISS;
        end
      end
      MISS:      if (fill_done_i) state_d = FILL_WAIT;    // Line written here
      FILL_WAIT: state_d = LOOKUP;                        // Memory re-reads set
      FLUSH:     if (flush_cnt_q == IDX_BITS'(SETS - 1)) state_d = LOOKUP;
      default:   state_d = LOOKUP;
    endcase
  end

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= LOOKUP;
      killed_q       <= 1'b0;
      flush_pend_q   <= 1'b0;
      flush_cnt_q    <= '0;
      parcel_valid_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (lookup_miss) begin
        killed_q <= 1'b0;
      end else if (flush_i && (state_q == MISS || state_q == FILL_WAIT)) begin
        killed_q <= 1'b1;                            // Fill completes, no parcel
      end
      if (state_q == LOOKUP && flush_go) begin
        flush_pend_q <= 1'b0;
      end else if (cache_flush_i) begin
        flush_pend_q <= 1'b1;
      end
      flush_cnt_q    <= (state_q == FLUSH) ? flush_cnt_q + 1'b1 : '0;
      parcel_valid_o <= lookup_hit || (state_q == FILL_WAIT && !killed_q && !flush_i);
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (lookup_miss) begin
      miss_adr_q <= setup_req_i.adr;
    end
    parcel_o <= (state_q == FILL_WAIT) ? fill_word : hit_word;
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  assign stall_o     = (state_q != LOOKUP) || flush_go;
  assign fill_we_o   = (state_q == MISS) && fill_done_i;
  assign flush_we_o  = (state_q == FLUSH);
  assign flush_idx_o = flush_cnt_q;
  assign wr_idx_o    = miss_adr_q.f.idx;
  assign cmp_tag_o   = (state_q == LOOKUP) ? setup_req_i.adr.f.tag : miss_adr_q.f.tag;

  // Command raised in the miss cycle, held in MISS
  assign fill_cmd_o.req      = lookup_miss || (state_q == MISS);
  assign fill_cmd_o.line_adr = (state_q == MISS) ? miss_adr_q.adr[PLEN-1:OFFS_BITS+2]
                                                 : setup_req_i.adr.adr[PLEN-1:OFFS_BITS+2];

endmodule

`default_nettype wire

//--- source/icache_setup.sv
// Address setup stage, fetch request register and memory read index select
`timescale 1ns/1ps
`default_nettype none

module icache_setup (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire logic                                stall_i,
  input  wire logic                                flush_i,
  input  wire logic                                req_i,
  input  wire icache_cfg_pkg::fetch_adr_t          adr_i,
  output icache_cfg_pkg::fetch_req_t               setup_req_o,
  output logic [icache_cfg_pkg::IDX_BITS-1:0]      rd_idx_o
);

  import icache_cfg_pkg::*;

  logic       valid_q;
  fetch_adr_t adr_q;

  // Request valid, killed by a pipeline flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= req_i;
    end
  end

  // Address payload, held while stalled
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      adr_q <= adr_i;
    end
  end

  assign setup_req_o.valid = valid_q;
  assign setup_req_o.adr   = adr_q;

  // Memory reads the set the hit stage judges next
  assign rd_idx_o = stall_i ? adr_q.f.idx : adr_i.f.idx;

endmodule

`default_nettype wire

//--- tb.f
common/icache_cfg_pkg.sv
common/icache_biu_pkg.sv
source/icache_setup.sv
icache_mem/icache_memory.sv
source/icache_hit_ctrl.sv
source/icache_biu_ctrl.sv
source/icache_core.sv
dv/biu_mem_model.sv
dv/tb_icache_core.sv
